// ==== hw/swd_params.svh ====
// sparse weight distributor parameters
// weight format, block geometry and buffer widths
`ifndef SWD_PARAMS_SVH
`define SWD_PARAMS_SVH

// ====================
// weight format
// ====================
// bits per weight
`define SWD_DATA_WIDTH 8
// packed weights per weight-buffer word
`define SWD_WEI_PER_WORD 4
`define SWD_WORD_WIDTH (`SWD_DATA_WIDTH * `SWD_WEI_PER_WORD)

// ====================
// block geometry
// ====================
// weights per kernel
`define SWD_BLOCK_DEPTH 4
// kernels per block, one expander each
`define SWD_KERNEL_SIZE 4
// dense lanes per block, also the mask width
`define SWD_LANES (`SWD_BLOCK_DEPTH * `SWD_KERNEL_SIZE)
// one full block plus one word of packed weights
`define SWD_QUEUE_DEPTH (`SWD_LANES + `SWD_WEI_PER_WORD)

// flag and weight buffer address width
`define SWD_ADDR_WIDTH 8

`endif

// ==== hw/swdPkg.sv ====
// shared types of the sparse weight distributor
// fetch FSM states and the width-derived queue and count types
`include "swd_params.svh"

package swdPkg;

    // fetch sequencing
    typedef enum logic [2:0] {
        Idle,
        FlagWait,
        Count,
        WeiRead,
        WeiWait,
        Expand,
        Finish
    } fetchState_t;

    // one packed weight
    typedef logic [`SWD_DATA_WIDTH-1:0] weight_t;

    // flattened packed queue, entry 0 is the oldest
    typedef logic [`SWD_QUEUE_DEPTH*`SWD_DATA_WIDTH-1:0] queue_t;

    // index into the packed queue, wide enough for its count too
    typedef logic [$clog2(`SWD_QUEUE_DEPTH+1)-1:0] offset_t;

    // set-bit count of a mask, 0 up to SWD_LANES
    typedef logic [$clog2(`SWD_LANES+1)-1:0] laneCount_t;

endpackage

// ==== hw/weightFetch.sv ====
// weight fetch block of the sparse weight distributor
// reads one mask per fetch, pulls packed weight words until the queue
// covers the mask popcount, then hands queue, mask and per-kernel
// offsets to the expanders and drops the consumed weights
`include "swd_params.svh"

module weightFetch import swdPkg::*; (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            fetch,
    output logic                            flagEnRd,
    output logic [`SWD_ADDR_WIDTH-1:0]      flagAddr,
    output logic                            weiEnRd,
    output logic [`SWD_ADDR_WIDTH-1:0]      weiAddr,
    input  logic [`SWD_LANES-1:0]           flagData,
    input  logic [`SWD_WORD_WIDTH-1:0]      weiData,
    output queue_t                          queueData,
    output logic [`SWD_LANES-1:0]           maskOut,
    output offset_t [`SWD_KERNEL_SIZE-1:0]  offsetBus,
    output logic                            expandGo,
    output logic                            busy
);

    fetchState_t state;
    weight_t     queue [`SWD_QUEUE_DEPTH];
    offset_t     queueCount;
    laneCount_t  popTotal;
    laneCount_t  kernelCnt [`SWD_KERNEL_SIZE];
    laneCount_t  flagCnt [`SWD_KERNEL_SIZE];
    laneCount_t  flagTotal;
    logic        accept;

    // ====================
    // buffer reads
    // ====================
    // a fetch only counts while idle
    assign accept   = fetch && (state == Idle);
    assign flagEnRd = accept;
    assign weiEnRd  = (state == WeiRead);
    assign expandGo = (state == Expand);
    assign busy     = (state != Idle);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flagAddr <= '0;
            weiAddr  <= '0;
        end else begin
            if (accept) begin
                flagAddr <= flagAddr + 1'b1;
            end
            if (weiEnRd) begin
                weiAddr <= weiAddr + 1'b1;
            end
        end
    end

    // ====================
    // mask popcount
    // ====================
    // per-kernel counts and the block total of the incoming mask
    always_comb begin
        flagTotal = '0;
        for (int k = 0; k < `SWD_KERNEL_SIZE; k++) begin
            flagCnt[k] = '0;
            for (int j = 0; j < `SWD_BLOCK_DEPTH; j++) begin
                flagCnt[k] = flagCnt[k] + laneCount_t'(flagData[k*`SWD_BLOCK_DEPTH + j]);
            end
            flagTotal = flagTotal + flagCnt[k];
        end
    end

    // kernel k starts after the nonzeros of all kernels below it
    always_comb begin
        offset_t running;
        running = '0;
        for (int k = 0; k < `SWD_KERNEL_SIZE; k++) begin
            offsetBus[k] = running;
            running      = running + offset_t'(kernelCnt[k]);
        end
    end

    // ====================
    // fetch FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= Idle;
            queueCount <= '0;
            popTotal   <= '0;
            maskOut    <= '0;
            for (int k = 0; k < `SWD_KERNEL_SIZE; k++) begin
                kernelCnt[k] <= '0;
            end
        end else begin
            case (state)
                Idle: begin
                    if (accept) begin
                        state <= FlagWait;
                    end
                end
                FlagWait: begin
                    // flag data is valid one cycle after the enable
                    maskOut  <= flagData;
                    popTotal <= flagTotal;
                    for (int k = 0; k < `SWD_KERNEL_SIZE; k++) begin
                        kernelCnt[k] <= flagCnt[k];
                    end
                    state <= Count;
                end
                Count: begin
                    if (queueCount < offset_t'(popTotal)) begin
                        state <= WeiRead;
                    end else begin
                        state <= Expand;
                    end
                end
                WeiRead: begin
                    state <= WeiWait;
                end
                WeiWait: begin
                    queueCount <= queueCount + offset_t'(`SWD_WEI_PER_WORD);
                    state      <= Count;
                end
                Expand: begin
                    state <= Finish;
                end
                Finish: begin
                    // leftovers stay for the next fetch
                    queueCount <= queueCount - offset_t'(popTotal);
                    state      <= Idle;
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // ====================
    // packed weight queue
    // ====================
    always_ff @(posedge clk) begin
        if (state == WeiWait) begin
            // append the word on top, lowest byte first
            for (int w = 0; w < `SWD_WEI_PER_WORD; w++) begin
                queue[int'(queueCount) + w] <= weiData[w*`SWD_DATA_WIDTH +: `SWD_DATA_WIDTH];
            end
        end else if (state == Finish) begin
            // shift out the weights this block consumed
            for (int i = 0; i < `SWD_QUEUE_DEPTH; i++) begin
                if (i + int'(popTotal) < `SWD_QUEUE_DEPTH) begin
                    queue[i] <= queue[i + int'(popTotal)];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `SWD_QUEUE_DEPTH; i++) begin
            queueData[i*`SWD_DATA_WIDTH +: `SWD_DATA_WIDTH] = queue[i];
        end
    end

endmodule

// ==== hw/kernelExpander.sv ====
// kernel expander
// turns one kernel's packed nonzero weights back into dense lanes,
// writing zero where the mask bit is clear
`include "swd_params.svh"

module kernelExpander import swdPkg::*; (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        go,
    input  queue_t                                      queueData,
    input  offset_t                                     offset,
    input  logic [`SWD_BLOCK_DEPTH-1:0]                 mask,
    output logic [`SWD_BLOCK_DEPTH*`SWD_DATA_WIDTH-1:0] lanes,
    output logic                                        laneValid
);

    logic [`SWD_BLOCK_DEPTH*`SWD_DATA_WIDTH-1:0] dense;

    // lane j takes entry offset plus the set bits below j
    always_comb begin
        offset_t idx;
        idx = offset;
        for (int j = 0; j < `SWD_BLOCK_DEPTH; j++) begin
            if (mask[j]) begin
                dense[j*`SWD_DATA_WIDTH +: `SWD_DATA_WIDTH] =
                    queueData[int'(idx)*`SWD_DATA_WIDTH +: `SWD_DATA_WIDTH];
                idx = idx + 1'b1;
            end else begin
                dense[j*`SWD_DATA_WIDTH +: `SWD_DATA_WIDTH] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            lanes <= dense;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            laneValid <= 1'b0;
        end else begin
            laneValid <= go;
        end
    end

endmodule

// ==== hw/pecWeightAssembler.sv ====
// PE-side weight assembler
// registers the dense lanes of all expanders and the block mask onto
// the PE buses, pulses weiValid and drives the ready level
`include "swd_params.svh"

module pecWeightAssembler (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  laneValid,
    input  logic [`SWD_LANES*`SWD_DATA_WIDTH-1:0] lanesIn,
    input  logic [`SWD_LANES-1:0]                 maskIn,
    input  logic                                  busy,
    output logic [`SWD_LANES*`SWD_DATA_WIDTH-1:0] peWei,
    output logic [`SWD_LANES-1:0]                 peFlag,
    output logic                                  weiValid,
    output logic                                  rdyWei
);

    // ====================
    // PE buses
    // ====================
    // outputs hold until the next block completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            peWei    <= '0;
            peFlag   <= '0;
            weiValid <= 1'b0;
        end else begin
            weiValid <= laneValid;
            if (laneValid) begin
                peWei  <= lanesIn;
                peFlag <= maskIn;
            end
        end
    end

    // low while the fetch block works, back up with the completion pulse
    assign rdyWei = !busy || weiValid;

endmodule

// ==== hw/sparseWeightDist.sv ====
// sparse weight distributor top level
// fetch block feeding one expander per kernel, drained by the
// PE-side assembler
`include "swd_params.svh"

module sparseWeightDist import swdPkg::*; (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  fetch,
    output logic                                  flagEnRd,
    output logic [`SWD_ADDR_WIDTH-1:0]            flagAddr,
    input  logic [`SWD_LANES-1:0]                 flagData,
    output logic                                  weiEnRd,
    output logic [`SWD_ADDR_WIDTH-1:0]            weiAddr,
    input  logic [`SWD_WORD_WIDTH-1:0]            weiData,
    output logic [`SWD_LANES*`SWD_DATA_WIDTH-1:0] peWei,
    output logic [`SWD_LANES-1:0]                 peFlag,
    output logic                                  weiValid,
    output logic                                  rdyWei
);

    queue_t                                queueData;
    logic [`SWD_LANES-1:0]                 maskOut;
    offset_t [`SWD_KERNEL_SIZE-1:0]        offsetBus;
    logic                                  expandGo;
    logic                                  busy;
    logic [`SWD_LANES*`SWD_DATA_WIDTH-1:0] laneBus;
    logic [`SWD_KERNEL_SIZE-1:0]           laneValidBus;

    weightFetch uFetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch     (fetch),
        .flagEnRd  (flagEnRd),
        .flagAddr  (flagAddr),
        .weiEnRd   (weiEnRd),
        .weiAddr   (weiAddr),
        .flagData  (flagData),
        .weiData   (weiData),
        .queueData (queueData),
        .maskOut   (maskOut),
        .offsetBus (offsetBus),
        .expandGo  (expandGo),
        .busy      (busy)
    );

    // ====================
    // one expander per kernel
    // ====================
    for (genvar k = 0; k < `SWD_KERNEL_SIZE; k++) begin : genExpander
        kernelExpander uExpander (
            .clk       (clk),
            .rst_n     (rst_n),
            .go        (expandGo),
            .queueData (queueData),
            .offset    (offsetBus[k]),
            .mask      (maskOut[k*`SWD_BLOCK_DEPTH +: `SWD_BLOCK_DEPTH]),
            .lanes     (laneBus[k*`SWD_BLOCK_DEPTH*`SWD_DATA_WIDTH +:
                                `SWD_BLOCK_DEPTH*`SWD_DATA_WIDTH]),
            .laneValid (laneValidBus[k])
        );
    end

    // all expanders run in lockstep, expander 0 stands for the block
    pecWeightAssembler uAssembler (
        .clk       (clk),
        .rst_n     (rst_n),
        .laneValid (laneValidBus[0]),
        .lanesIn   (laneBus),
        .maskIn    (maskOut),
        .busy      (busy),
        .peWei     (peWei),
        .peFlag    (peFlag),
        .weiValid  (weiValid),
        .rdyWei    (rdyWei)
    );

endmodule

// ==== test/sparseWeightDist_properties.sv ====
// protocol checks of the sparse weight distributor
// ready after reset, single-cycle valid, and read enable spacing
module sparseWeightDist_properties (
    input logic clk,
    input logic rst_n,
    input logic rdyWei,
    input logic weiValid,
    input logic flagEnRd,
    input logic weiEnRd
);
    timeunit 1ns;
    timeprecision 100ps;

    readyAfterReset: assert property (@(posedge clk) $rose(rst_n) |-> rdyWei)
        else $error("rdyWei is low right after reset");

    validPulse: assert property (@(posedge clk) disable iff (!rst_n) weiValid |=> !weiValid)
        else $error("weiValid held for more than one cycle");

    // a mask read means the fetch was accepted
    flagReadWhenReady: assert property (@(posedge clk) disable iff (!rst_n)
        flagEnRd |-> rdyWei)
        else $error("flagEnRd fired while rdyWei was low");

    weiReadSpacing: assert property (@(posedge clk) disable iff (!rst_n) weiEnRd |=> !weiEnRd)
        else $error("weiEnRd fired in two consecutive cycles");

endmodule

bind sparseWeightDist sparseWeightDist_properties uProps (
    .clk      (clk),
    .rst_n    (rst_n),
    .rdyWei   (rdyWei),
    .weiValid (weiValid),
    .flagEnRd (flagEnRd),
    .weiEnRd  (weiEnRd)
);

// ==== test/sparseWeightDist_tb.sv ====
// testbench of the sparse weight distributor
// LFSR masks and packed weights, flag and weight buffer models with one
// cycle read latency, and a reference model of the dense expansion
`include "swd_params.svh"

module sparseWeightDist_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BlockBits = `SWD_LANES * `SWD_DATA_WIDTH;
    localparam int AddrBits  = `SWD_ADDR_WIDTH;
    localparam int MemDepth  = 1 << `SWD_ADDR_WIDTH;
    localparam int NumRandom = 40;
    localparam int WaitLimit = 200;

    logic                        clk, rst_n, fetch;
    logic                        flagEnRd, weiEnRd, weiValid, rdyWei;
    logic [AddrBits-1:0]         flagAddr, weiAddr;
    logic [`SWD_LANES-1:0]       flagData, peFlag;
    logic [`SWD_WORD_WIDTH-1:0]  weiData;
    logic [BlockBits-1:0]        peWei;

    logic [`SWD_LANES-1:0]       flagMem [MemDepth];
    logic [`SWD_WORD_WIDTH-1:0]  weiMem [MemDepth];
    logic                        flagPend, weiPend;
    logic [AddrBits-1:0]         flagRdAddr, weiRdAddr;
    logic [31:0]                 lfsr;
    int errors, testsPassed, testsFailed;
    int fetchIdx, rdPtr, queueFill, wordsUsed;

    sparseWeightDist UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch    (fetch),
        .flagEnRd (flagEnRd),
        .flagAddr (flagAddr),
        .flagData (flagData),
        .weiEnRd  (weiEnRd),
        .weiAddr  (weiAddr),
        .weiData  (weiData),
        .peWei    (peWei),
        .peFlag   (peFlag),
        .weiValid (weiValid),
        .rdyWei   (rdyWei)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ====================
    // buffer models
    // ====================
    // requests taken mid-cycle, data driven just after the next edge
    always @(negedge clk) begin
        flagPend   = flagEnRd;
        flagRdAddr = flagAddr;
        weiPend    = weiEnRd;
        weiRdAddr  = weiAddr;
    end

    always @(posedge clk) begin
        #1;
        if (flagPend) begin
            flagData = flagMem[flagRdAddr];
        end
        if (weiPend) begin
            weiData = weiMem[weiRdAddr];
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BC_D35C) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // i-th nonzero weight of the packed stream
    function automatic logic [`SWD_DATA_WIDTH-1:0] weightAt(input int i);
        logic [`SWD_WORD_WIDTH-1:0] word;
        word = weiMem[AddrBits'(i / `SWD_WEI_PER_WORD)];
        return word[(i % `SWD_WEI_PER_WORD) * `SWD_DATA_WIDTH +: `SWD_DATA_WIDTH];
    endfunction

    task automatic checkValue(input string name, input logic [BlockBits-1:0] got,
                              input logic [BlockBits-1:0] expected);
        if (got !== expected) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errors == errorsBefore) begin
            testsPassed++;
            $display("PASS %s", name);
        end else begin
            testsFailed++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic pulseFetch();
        @(posedge clk);
        #1 fetch = 1'b1;
        @(posedge clk);
        #1 fetch = 1'b0;
    endtask

    task automatic waitValid();
        int cycles;
        cycles = 0;
        while (weiValid !== 1'b1 && cycles < WaitLimit) begin
            // ready stays low until the block is done
            checkValue("rdyWei", BlockBits'(rdyWei), BlockBits'(1'b0));
            @(negedge clk);
            cycles++;
        end
        if (weiValid !== 1'b1) begin
            $display("timeout at %0t ns: no weiValid after the fetch", $time);
            errors++;
        end
    endtask

    // ====================
    // reference model
    // ====================
    // mask bit order, oldest packed weight first, zero on clear bits
    task automatic checkBlock(input logic [`SWD_LANES-1:0] mask);
        logic [BlockBits-1:0] expected;
        int need;
        expected = '0;
        need     = 0;
        for (int l = 0; l < `SWD_LANES; l++) begin
            if (mask[l]) begin
                expected[l*`SWD_DATA_WIDTH +: `SWD_DATA_WIDTH] = weightAt(rdPtr + need);
                need++;
            end
        end
        rdPtr += need;
        // whole words until the leftovers cover the block
        while (queueFill < need) begin
            queueFill += `SWD_WEI_PER_WORD;
            wordsUsed++;
        end
        queueFill -= need;
        checkValue("peWei", peWei, expected);
        checkValue("peFlag", BlockBits'(peFlag), BlockBits'(mask));
        checkValue("rdyWei", BlockBits'(rdyWei), BlockBits'(1'b1));
        checkValue("weiAddr", BlockBits'(weiAddr), BlockBits'(wordsUsed));
    endtask

    task automatic runFetch();
        logic [`SWD_LANES-1:0] mask;
        mask = flagMem[AddrBits'(fetchIdx)];
        fetchIdx++;
        pulseFetch();
        waitValid();
        checkBlock(mask);
    endtask

    initial begin
        int mark;
        logic [31:0] rnd;
        logic [`SWD_WORD_WIDTH-1:0] word;
        logic [AddrBits-1:0] addrBefore;
        logic [`SWD_LANES-1:0] mask;
        errors      = 0;
        testsPassed = 0;
        testsFailed = 0;
        fetchIdx    = 0;
        rdPtr       = 0;
        queueFill   = 0;
        wordsUsed   = 0;
        lfsr        = 32'hbe1e_7f8a;
        for (int a = 0; a < MemDepth; a++) begin
            rnd = randBits(`SWD_LANES);
            flagMem[AddrBits'(a)] = rnd[`SWD_LANES-1:0];
            for (int b = 0; b < `SWD_WEI_PER_WORD; b++) begin
                rnd = randBits(`SWD_DATA_WIDTH);
                // packed weights are nonzero by definition
                if (rnd[`SWD_DATA_WIDTH-1:0] == '0) begin
                    rnd[0] = 1'b1;
                end
                word[b*`SWD_DATA_WIDTH +: `SWD_DATA_WIDTH] = rnd[`SWD_DATA_WIDTH-1:0];
            end
            weiMem[AddrBits'(a)] = word;
        end
        // corner masks follow the random run
        flagMem[AddrBits'(NumRandom)]     = '0;
        flagMem[AddrBits'(NumRandom + 1)] = '1;

        rst_n      = 1'b0;
        fetch      = 1'b0;
        flagData   = '0;
        weiData    = '0;
        flagPend   = 1'b0;
        weiPend    = 1'b0;
        flagRdAddr = '0;
        weiRdAddr  = '0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        @(negedge clk);
        mark = errors;
        checkValue("rdyWei", BlockBits'(rdyWei), BlockBits'(1'b1));
        checkValue("weiValid", BlockBits'(weiValid), BlockBits'(1'b0));
        checkValue("flagAddr", BlockBits'(flagAddr), '0);
        checkValue("weiAddr", BlockBits'(weiAddr), '0);
        reportTest("reset state", mark);

        mark = errors;
        repeat (NumRandom) runFetch();
        reportTest("random fetches", mark);

        // all-zero mask reads no word, all-ones takes 16 weights
        mark       = errors;
        addrBefore = weiAddr;
        runFetch();
        checkValue("weiAddr", BlockBits'(weiAddr), BlockBits'(addrBefore));
        runFetch();
        reportTest("corner masks", mark);

        // second pulse lands while rdyWei is low
        mark       = errors;
        addrBefore = flagAddr;
        mask       = flagMem[AddrBits'(fetchIdx)];
        fetchIdx++;
        pulseFetch();
        pulseFetch();
        waitValid();
        checkBlock(mask);
        checkValue("flagAddr", BlockBits'(flagAddr), BlockBits'(addrBefore + 1'b1));
        reportTest("fetch while busy", mark);

        mark = errors;
        checkValue("weiAddr", BlockBits'(weiAddr), BlockBits'(wordsUsed));
        reportTest("carry-over word count", mark);

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 testsPassed, testsFailed, errors);
        if (errors == 0 && testsFailed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+hw
hw/swdPkg.sv
hw/weightFetch.sv
hw/kernelExpander.sv
hw/pecWeightAssembler.sv
hw/sparseWeightDist.sv
test/sparseWeightDist_properties.sv
test/sparseWeightDist_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the sparse weight distributor testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module sparseWeightDist_tb --Mdir obj_dir -o simv -f build.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0
